/* axi_read_xbar.f */
design/axi_read_pkg.sv
design/axi_read_chan_if.sv
design/master_port_arbiter.sv
design/slave_route_decoder.sv
design/decerr_responder.sv
design/axi_read_xbar.sv
test/tb_slave_model.sv
test/axi_read_xbar_tb.sv

/* design/axi_read_chan_if.sv */
//****************************************************************************
// Read-address and read-data channel bundles for the crossbar
// Both use a valid/ready handshake, payload held until transfer
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

interface ar_chan_if;
    import axi_read_pkg::*;

    logic              valid;
    logic              ready;
    logic [ADDR_W-1:0] addr;
    logic [SID_W-1:0]  id;
    logic [LEN_W-1:0]  len;

    modport src (output valid, addr, id, len, input ready);
    modport dst (input valid, addr, id, len, output ready);

endinterface

interface r_chan_if;
    import axi_read_pkg::*;

    logic              valid;
    logic              ready;
    logic [DATA_W-1:0] data;
    logic [SID_W-1:0]  id;
    resp_t             resp;
    logic              last;

    // Slave side sources the beats
    modport src (output valid, data, id, resp, last, input ready);
    modport dst (input valid, data, id, resp, last, output ready);

endinterface

`default_nettype wire

/* design/axi_read_pkg.sv */
//****************************************************************************
// Read crossbar shared definitions
// Bus widths, region decode position, response codes and route targets
//****************************************************************************
`default_nettype none

package axi_read_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 4;

    // Master index sits above the master's own ID on the slave side
    localparam int MTAG_W = 2;
    localparam int SID_W  = ID_W + MTAG_W;

    // External slaves, one per address region starting at region 0
    localparam int N_SLAVES = 3;

    // Region nibble is the top of the address
    localparam int REGION_LSB = 28;

    // Read response codes
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // Route target, 0 to N_SLAVES-1 are external slaves
    typedef logic [1:0] slave_sel_t;

    localparam slave_sel_t DEFAULT_SLAVE = 2'd3;

endpackage

`default_nettype wire

/* design/axi_read_xbar.sv */
//****************************************************************************
// Read-only AXI crossbar, N masters to three slaves plus a default slave
// One burst open at a time, round-robin between masters
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

module axi_read_xbar #(
    parameter int N_MASTERS = 3
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    // Master ports
    input  wire logic [N_MASTERS-1:0]                  m_ar_valid,
    output logic      [N_MASTERS-1:0]                  m_ar_ready,
    input  wire logic [axi_read_pkg::ADDR_W-1:0]       m_ar_addr [N_MASTERS],
    input  wire logic [axi_read_pkg::ID_W-1:0]         m_ar_id [N_MASTERS],
    input  wire logic [axi_read_pkg::LEN_W-1:0]        m_ar_len [N_MASTERS],
    output logic      [N_MASTERS-1:0]                  m_r_valid,
    input  wire logic [N_MASTERS-1:0]                  m_r_ready,
    output logic      [axi_read_pkg::DATA_W-1:0]       m_r_data [N_MASTERS],
    output logic      [axi_read_pkg::ID_W-1:0]         m_r_id [N_MASTERS],
    output axi_read_pkg::resp_t                        m_r_resp [N_MASTERS],
    output logic      [N_MASTERS-1:0]                  m_r_last,
    // Slave ports
    output logic      [axi_read_pkg::N_SLAVES-1:0]     s_ar_valid,
    input  wire logic [axi_read_pkg::N_SLAVES-1:0]     s_ar_ready,
    output logic      [axi_read_pkg::ADDR_W-1:0]       s_ar_addr [axi_read_pkg::N_SLAVES],
    output logic      [axi_read_pkg::SID_W-1:0]        s_ar_id [axi_read_pkg::N_SLAVES],
    output logic      [axi_read_pkg::LEN_W-1:0]        s_ar_len [axi_read_pkg::N_SLAVES],
    input  wire logic [axi_read_pkg::N_SLAVES-1:0]     s_r_valid,
    output logic      [axi_read_pkg::N_SLAVES-1:0]     s_r_ready,
    input  wire logic [axi_read_pkg::DATA_W-1:0]       s_r_data [axi_read_pkg::N_SLAVES],
    input  wire logic [axi_read_pkg::SID_W-1:0]        s_r_id [axi_read_pkg::N_SLAVES],
    input  wire axi_read_pkg::resp_t                   s_r_resp [axi_read_pkg::N_SLAVES],
    input  wire logic [axi_read_pkg::N_SLAVES-1:0]     s_r_last
);

    // Arbiter to decoder, and decoder to default slave
    ar_chan_if xbar_ar ();
    r_chan_if  xbar_r ();
    ar_chan_if dflt_ar ();
    r_chan_if  dflt_r ();

    logic txn_done;

    master_port_arbiter #(
        .N_MASTERS (N_MASTERS)
    ) u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_ar_addr  (m_ar_addr),
        .m_ar_id    (m_ar_id),
        .m_ar_len   (m_ar_len),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready),
        .m_r_data   (m_r_data),
        .m_r_id     (m_r_id),
        .m_r_resp   (m_r_resp),
        .m_r_last   (m_r_last),
        .txn_done   (txn_done),
        .req        (xbar_ar.src),
        .rsp        (xbar_r.dst)
    );

    slave_route_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_ar_addr  (s_ar_addr),
        .s_ar_id    (s_ar_id),
        .s_ar_len   (s_ar_len),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready),
        .s_r_data   (s_r_data),
        .s_r_id     (s_r_id),
        .s_r_resp   (s_r_resp),
        .s_r_last   (s_r_last),
        .txn_done   (txn_done),
        .req        (xbar_ar.dst),
        .rsp        (xbar_r.src),
        .dflt_req   (dflt_ar.src),
        .dflt_rsp   (dflt_r.dst)
    );

    decerr_responder u_default_slave (
        .clk (clk),
        .rst (rst),
        .req (dflt_ar.dst),
        .rsp (dflt_r.src)
    );

endmodule

`default_nettype wire

/* design/decerr_responder.sv */
//****************************************************************************
// Default slave for unmapped regions
// Returns a full burst of zero data with a decode-error response
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

module decerr_responder (
    input  wire logic clk,
    input  wire logic rst,
    ar_chan_if.dst    req,
    r_chan_if.src     rsp
);
    import axi_read_pkg::*;

    logic             busy;
    logic [LEN_W-1:0] beats_left;
    logic [SID_W-1:0] id_q;

    // Accepts a new request only when no burst is pending
    assign req.ready = !busy;

    assign rsp.valid = busy;
    assign rsp.data  = '0;
    assign rsp.id    = id_q;
    assign rsp.resp  = RESP_DECERR;
    assign rsp.last  = (beats_left == '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            beats_left <= '0;
        end
        else if (!busy)
        begin
            if (req.valid)
            begin
                busy       <= 1'b1;
                beats_left <= req.len;
            end
        end
        else if (rsp.ready)
        begin
            // One beat gone per transfer
            if (rsp.last)
            begin
                busy <= 1'b0;
            end
            else
            begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && req.valid)
        begin
            id_q <= req.id;
        end
    end

    // Decoder keeps new requests away until the burst is over
    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !req.valid);

endmodule

`default_nettype wire

/* design/master_port_arbiter.sv */
//****************************************************************************
// Master-side round-robin arbiter of the read crossbar
// Locks one master per burst, tags its ID and returns its read data
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

module master_port_arbiter #(
    parameter int N_MASTERS = 3
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [N_MASTERS-1:0]              m_ar_valid,
    output logic      [N_MASTERS-1:0]              m_ar_ready,
    input  wire logic [axi_read_pkg::ADDR_W-1:0]   m_ar_addr [N_MASTERS],
    input  wire logic [axi_read_pkg::ID_W-1:0]     m_ar_id [N_MASTERS],
    input  wire logic [axi_read_pkg::LEN_W-1:0]    m_ar_len [N_MASTERS],
    output logic      [N_MASTERS-1:0]              m_r_valid,
    input  wire logic [N_MASTERS-1:0]              m_r_ready,
    output logic      [axi_read_pkg::DATA_W-1:0]   m_r_data [N_MASTERS],
    output logic      [axi_read_pkg::ID_W-1:0]     m_r_id [N_MASTERS],
    output axi_read_pkg::resp_t                    m_r_resp [N_MASTERS],
    output logic      [N_MASTERS-1:0]              m_r_last,
    input  wire logic                              txn_done,
    ar_chan_if.src                                 req,
    r_chan_if.dst                                  rsp
);
    import axi_read_pkg::*;

    logic              grant_valid;
    // Current grant, kept after release as the round-robin pointer
    logic [MTAG_W-1:0] grant_idx;
    logic              pick_found;
    logic [MTAG_W-1:0] pick_idx;
    logic [N_MASTERS-1:0] grant_hit;

    // Search starts one past the last granted master
    always_comb
    begin
        int cand;
        pick_found = 1'b0;
        pick_idx   = grant_idx;
        for (int i = 1; i <= N_MASTERS; i++)
        begin
            cand = (int'(grant_idx) + i) % N_MASTERS;
            if (!pick_found && m_ar_valid[cand])
            begin
                pick_found = 1'b1;
                pick_idx   = MTAG_W'(cand);
            end
        end
    end

    // Grant is released on txn_done and may be re-granted on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            grant_valid <= 1'b0;
            grant_idx   <= MTAG_W'(N_MASTERS - 1);
        end
        else if (!grant_valid || txn_done)
        begin
            grant_valid <= pick_found;
            if (pick_found)
            begin
                grant_idx <= pick_idx;
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < N_MASTERS; i++)
        begin
            grant_hit[i] = grant_valid && (grant_idx == MTAG_W'(i));
        end
    end

    // Granted request with its master index prepended to the ID
    always_comb
    begin
        req.valid = grant_valid && m_ar_valid[grant_idx];
        req.addr  = m_ar_addr[grant_idx];
        req.id    = {grant_idx, m_ar_id[grant_idx]};
        req.len   = m_ar_len[grant_idx];
        rsp.ready = grant_valid && m_r_ready[grant_idx];
    end

    // Handshakes only reach the granted master, payload is shared
    always_comb
    begin
        for (int i = 0; i < N_MASTERS; i++)
        begin
            m_ar_ready[i] = grant_hit[i] && req.ready;
            m_r_valid[i]  = grant_hit[i] && rsp.valid;
            m_r_data[i]   = rsp.data;
            m_r_id[i]     = rsp.id[ID_W-1:0];
            m_r_resp[i]   = rsp.resp;
            m_r_last[i]   = rsp.last;
        end
    end

    // Burst end only while a master holds the bus
    done_needs_grant: assert property (@(posedge clk) disable iff (rst)
        txn_done |-> grant_valid);

    // Returned tag names the master the burst was issued for
    tag_matches_grant: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |-> grant_valid && (rsp.id[SID_W-1 -: MTAG_W] == grant_idx));

endmodule

`default_nettype wire

/* design/slave_route_decoder.sv */
//****************************************************************************
// Slave-side route decoder of the read crossbar
// Maps the region nibble to one target and holds it for the data phase
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

module slave_route_decoder (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    output logic      [axi_read_pkg::N_SLAVES-1:0]           s_ar_valid,
    input  wire logic [axi_read_pkg::N_SLAVES-1:0]           s_ar_ready,
    output logic      [axi_read_pkg::ADDR_W-1:0]             s_ar_addr [axi_read_pkg::N_SLAVES],
    output logic      [axi_read_pkg::SID_W-1:0]              s_ar_id [axi_read_pkg::N_SLAVES],
    output logic      [axi_read_pkg::LEN_W-1:0]              s_ar_len [axi_read_pkg::N_SLAVES],
    input  wire logic [axi_read_pkg::N_SLAVES-1:0]           s_r_valid,
    output logic      [axi_read_pkg::N_SLAVES-1:0]           s_r_ready,
    input  wire logic [axi_read_pkg::DATA_W-1:0]             s_r_data [axi_read_pkg::N_SLAVES],
    input  wire logic [axi_read_pkg::SID_W-1:0]              s_r_id [axi_read_pkg::N_SLAVES],
    input  wire axi_read_pkg::resp_t                         s_r_resp [axi_read_pkg::N_SLAVES],
    input  wire logic [axi_read_pkg::N_SLAVES-1:0]           s_r_last,
    output logic                                             txn_done,
    ar_chan_if.dst                                           req,
    r_chan_if.src                                            rsp,
    ar_chan_if.src                                           dflt_req,
    r_chan_if.dst                                            dflt_rsp
);
    import axi_read_pkg::*;

    localparam int REGION_W = ADDR_W - REGION_LSB;

    logic [REGION_W-1:0] region;
    slave_sel_t          addr_sel;
    logic                data_phase;
    slave_sel_t          route_sel;

    // Regions past the external slaves fall to the default slave
    always_comb
    begin
        region = req.addr[ADDR_W-1:REGION_LSB];
        if (region < REGION_W'(N_SLAVES))
        begin
            addr_sel = slave_sel_t'(region);
        end
        else
        begin
            addr_sel = DEFAULT_SLAVE;
        end
    end

    // Address steering, only in address phase
    always_comb
    begin
        for (int s = 0; s < N_SLAVES; s++)
        begin
            s_ar_valid[s] = !data_phase && req.valid && (addr_sel == slave_sel_t'(s));
            s_ar_addr[s]  = req.addr;
            s_ar_id[s]    = req.id;
            s_ar_len[s]   = req.len;
        end
        dflt_req.valid = !data_phase && req.valid && (addr_sel == DEFAULT_SLAVE);
        dflt_req.addr  = req.addr;
        dflt_req.id    = req.id;
        dflt_req.len   = req.len;

        req.ready = 1'b0;
        if (!data_phase)
        begin
            if (addr_sel == DEFAULT_SLAVE)
            begin
                req.ready = dflt_req.ready;
            end
            else
            begin
                req.ready = s_ar_ready[addr_sel];
            end
        end
    end

    // Beats and ready follow the latched target
    always_comb
    begin
        for (int s = 0; s < N_SLAVES; s++)
        begin
            s_r_ready[s] = data_phase && (route_sel == slave_sel_t'(s)) && rsp.ready;
        end
        dflt_rsp.ready = data_phase && (route_sel == DEFAULT_SLAVE) && rsp.ready;

        if (route_sel == DEFAULT_SLAVE)
        begin
            rsp.valid = data_phase && dflt_rsp.valid;
            rsp.data  = dflt_rsp.data;
            rsp.id    = dflt_rsp.id;
            rsp.resp  = dflt_rsp.resp;
            rsp.last  = dflt_rsp.last;
        end
        else
        begin
            rsp.valid = data_phase && s_r_valid[route_sel];
            rsp.data  = s_r_data[route_sel];
            rsp.id    = s_r_id[route_sel];
            rsp.resp  = s_r_resp[route_sel];
            rsp.last  = s_r_last[route_sel];
        end
    end

    assign txn_done = rsp.valid && rsp.ready && rsp.last;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            data_phase <= 1'b0;
            route_sel  <= DEFAULT_SLAVE;
        end
        else if (!data_phase && req.valid && req.ready)
        begin
            data_phase <= 1'b1;
            route_sel  <= addr_sel;
        end
        else if (txn_done)
        begin
            data_phase <= 1'b0;
        end
    end

    // An offered address stays up until its slave takes it
    addr_held_until_taken: assert property (@(posedge clk) disable iff (rst)
        (s_ar_valid & ~s_ar_ready) != '0 |=> $stable(s_ar_valid));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the read crossbar testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module axi_read_xbar_tb \
    -f axi_read_xbar.f -Mdir obj_dir &&
./obj_dir/Vaxi_read_xbar_tb ||
{ echo "Simulation failed"; exit 1; }

/* test/axi_read_xbar_tb.sv */
//****************************************************************************
// Testbench for the read crossbar
// Three masters read from three memory slave models and the default slave
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

module axi_read_xbar_tb;
    import axi_read_pkg::*;

    localparam int N_MASTERS  = 3;
    localparam int CLK_PERIOD = 40;
    localparam int MAX_STALL  = 3;
    // Reads over all phases, 3 + 4 + 12 + 9
    localparam int N_TXN      = 28;
    // Up to 16 beats per read, stalled by the slave and by the master
    localparam int WATCHDOG_NS = (N_TXN * 16 * (MAX_STALL + 1) * 2 + 200) * CLK_PERIOD;

    logic                 clk;
    logic                 rst;
    logic [N_MASTERS-1:0] m_ar_valid;
    logic [N_MASTERS-1:0] m_ar_ready;
    logic [ADDR_W-1:0]    m_ar_addr [N_MASTERS];
    logic [ID_W-1:0]      m_ar_id [N_MASTERS];
    logic [LEN_W-1:0]     m_ar_len [N_MASTERS];
    logic [N_MASTERS-1:0] m_r_valid;
    logic [N_MASTERS-1:0] m_r_ready;
    logic [DATA_W-1:0]    m_r_data [N_MASTERS];
    logic [ID_W-1:0]      m_r_id [N_MASTERS];
    resp_t                m_r_resp [N_MASTERS];
    logic [N_MASTERS-1:0] m_r_last;
    logic [N_SLAVES-1:0]  s_ar_valid;
    logic [N_SLAVES-1:0]  s_ar_ready;
    logic [ADDR_W-1:0]    s_ar_addr [N_SLAVES];
    logic [SID_W-1:0]     s_ar_id [N_SLAVES];
    logic [LEN_W-1:0]     s_ar_len [N_SLAVES];
    logic [N_SLAVES-1:0]  s_r_valid;
    logic [N_SLAVES-1:0]  s_r_ready;
    logic [DATA_W-1:0]    s_r_data [N_SLAVES];
    logic [SID_W-1:0]     s_r_id [N_SLAVES];
    resp_t                s_r_resp [N_SLAVES];
    logic [N_SLAVES-1:0]  s_r_last;

    // Open reads per master as {addr, id, len}
    logic [39:0] pend_q [N_MASTERS][$];
    int          done_order [$];
    int          outstanding;
    int          rready_pct;

    axi_read_xbar #(
        .N_MASTERS (N_MASTERS)
    ) UUT (.*);

    for (genvar s = 0; s < N_SLAVES; s++)
    begin : g_slave
        tb_slave_model #(
            .MAX_STALL (MAX_STALL)
        ) u_mem (
            .clk      (clk),
            .rst      (rst),
            .ar_valid (s_ar_valid[s]),
            .ar_ready (s_ar_ready[s]),
            .ar_addr  (s_ar_addr[s]),
            .ar_id    (s_ar_id[s]),
            .ar_len   (s_ar_len[s]),
            .r_valid  (s_r_valid[s]),
            .r_ready  (s_r_ready[s]),
            .r_data   (s_r_data[s]),
            .r_id     (s_r_id[s]),
            .r_resp   (s_r_resp[s]),
            .r_last   (s_r_last[s])
        );
    end

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected)
        begin
            abort_run($sformatf("mismatch at %0t ns: %s, got %0h, expected %0h",
                                $time, what, got, expected));
        end
    endtask

    // Expected {resp, data} of one beat from the address map
    function automatic logic [33:0] expected_beat(input logic [ADDR_W-1:0] addr,
                                                  input int beat);
        logic [3:0] region;
        region = addr[ADDR_W-1:REGION_LSB];
        if (region < 4'd3)
        begin
            return {RESP_OKAY, addr + ADDR_W'(4 * beat)};
        end
        return {RESP_DECERR, 32'd0};
    endfunction

    // Word aligned address with a small random offset inside a region
    function automatic logic [ADDR_W-1:0] word_addr(input int region);
        return {4'(region), 18'd0, 8'($urandom), 2'b00};
    endfunction

    task automatic issue_read(input int m, input logic [ADDR_W-1:0] addr,
                              input logic [ID_W-1:0] id, input logic [LEN_W-1:0] len);
        logic accepted;
        pend_q[m].push_back({addr, id, len});
        outstanding++;
        m_ar_valid[m] = 1'b1;
        m_ar_addr[m]  = addr;
        m_ar_id[m]    = id;
        m_ar_len[m]   = len;
        accepted      = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = m_ar_ready[m];
            @(posedge clk);
            #2;
        end
        m_ar_valid[m] = 1'b0;
    endtask

    task automatic issue_stream(input int m, input int count, input int regions);
        for (int k = 0; k < count; k++)
        begin
            issue_read(m, word_addr(int'($urandom % regions)), 4'($urandom), 4'($urandom));
        end
    endtask

    task automatic wait_all_done();
        wait (outstanding == 0);
        @(posedge clk);
        #2;
    endtask

    // Master read-data ready, random when rready_pct is below 100
    initial
    begin
        m_r_ready = '0;
        forever
        begin
            @(posedge clk);
            #2;
            for (int m = 0; m < N_MASTERS; m++)
            begin
                m_r_ready[m] = int'($urandom % 100) < rready_pct;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout: reads still open after %0d ns", WATCHDOG_NS));
    end

    // Slave address side follows the region and carries the master tag
    initial
    begin : addr_check
        logic [3:0] region;
        forever
        begin
            @(negedge clk);
            for (int s = 0; s < N_SLAVES; s++)
            begin
                if (s_ar_valid[s])
                begin
                    check_value(s_ar_addr[s][ADDR_W-1:REGION_LSB], s, "slave address region");
                end
            end
            for (int m = 0; m < N_MASTERS; m++)
            begin
                if (m_ar_valid[m] && m_ar_ready[m])
                begin
                    region = m_ar_addr[m][ADDR_W-1:REGION_LSB];
                    if (region < N_SLAVES)
                    begin
                        check_value(s_ar_valid[region] && s_ar_ready[region], 1'b1,
                                    "slave address handshake");
                        check_value(s_ar_id[region], {2'(m), m_ar_id[m]}, "slave-side ID");
                        check_value(s_ar_len[region], m_ar_len[m], "slave burst length");
                    end
                    else
                    begin
                        check_value(s_ar_valid, '0, "slave address valid on unmapped read");
                    end
                end
            end
        end
    end

    for (genvar g = 0; g < N_MASTERS; g++)
    begin : g_check
        initial
        begin : beat_check
            logic [39:0]       cur;
            logic [33:0]       exp_beat;
            logic [DATA_W-1:0] held_data;
            logic              held_last;
            logic              holding;
            int                beat;
            beat    = 0;
            holding = 1'b0;
            forever
            begin
                @(negedge clk);
                // Payload frozen while the master stalls
                if (holding)
                begin
                    check_value(m_r_valid[g], 1'b1, $sformatf("master %0d stalled valid", g));
                    check_value(m_r_data[g], held_data, $sformatf("master %0d stalled data", g));
                    check_value(m_r_last[g], held_last, $sformatf("master %0d stalled last", g));
                end
                if (m_r_valid[g] && m_r_ready[g])
                begin
                    if (pend_q[g].size() == 0)
                    begin
                        abort_run($sformatf("Master %0d got a read beat with no read open", g));
                    end
                    else
                    begin
                        cur      = pend_q[g][0];
                        exp_beat = expected_beat(cur[39:8], beat);
                        check_value(m_r_data[g], exp_beat[31:0], "read data");
                        check_value(m_r_resp[g], exp_beat[33:32], "read response");
                        check_value(m_r_id[g], cur[7:4], "read ID");
                        check_value(m_r_last[g], beat == int'(cur[3:0]), "last flag");
                        if (beat == int'(cur[3:0]))
                        begin
                            void'(pend_q[g].pop_front());
                            done_order.push_back(g);
                            outstanding--;
                            beat = 0;
                        end
                        else
                        begin
                            beat++;
                        end
                    end
                end
                holding   = m_r_valid[g] && !m_r_ready[g];
                held_data = m_r_data[g];
                held_last = m_r_last[g];
            end
        end
    end

    initial
    begin
        void'($urandom(84));
        rst         = 1'b1;
        m_ar_valid  = '0;
        outstanding = 0;
        rready_pct  = 100;
        for (int m = 0; m < N_MASTERS; m++)
        begin
            m_ar_addr[m] = '0;
            m_ar_id[m]   = '0;
            m_ar_len[m]  = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // Quiet bus before any request
        @(negedge clk);
        check_value(m_ar_ready, '0, "m_ar_ready after reset");
        check_value(m_r_valid, '0, "m_r_valid after reset");
        check_value(s_ar_valid, '0, "s_ar_valid after reset");
        @(posedge clk);
        #2;

        // One read to each mapped region
        for (int r = 0; r < N_SLAVES; r++)
        begin
            issue_read(r, word_addr(r), 4'($urandom), 4'($urandom));
            wait_all_done();
        end

        // Unmapped regions 3 to 15
        for (int k = 0; k < 4; k++)
        begin
            issue_read(k % N_MASTERS, word_addr(3 + int'($urandom % 13)),
                       4'($urandom), 4'($urandom));
            wait_all_done();
        end

        // All masters requesting back to back
        done_order.delete();
        fork
            issue_stream(0, 4, N_SLAVES);
            issue_stream(1, 4, N_SLAVES);
            issue_stream(2, 4, N_SLAVES);
        join
        wait_all_done();
        check_value(done_order.size(), 12, "reads completed under contention");
        for (int k = 1; k < done_order.size(); k++)
        begin
            check_value(done_order[k], (done_order[k - 1] + 1) % N_MASTERS, "round-robin order");
        end

        // Master back-pressure over all regions
        rready_pct = 50;
        fork
            issue_stream(0, 3, 16);
            issue_stream(1, 3, 16);
            issue_stream(2, 3, 16);
        join
        wait_all_done();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_slave_model.sv */
//****************************************************************************
// Memory slave model for the read crossbar testbench
// Returns the beat address as data, with random address and data stalls
//****************************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_slave_model #(
    parameter int MAX_STALL = 3
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              ar_valid,
    output logic                                   ar_ready,
    input  wire logic [axi_read_pkg::ADDR_W-1:0]   ar_addr,
    input  wire logic [axi_read_pkg::SID_W-1:0]    ar_id,
    input  wire logic [axi_read_pkg::LEN_W-1:0]    ar_len,
    output logic                                   r_valid,
    input  wire logic                              r_ready,
    output logic      [axi_read_pkg::DATA_W-1:0]   r_data,
    output logic      [axi_read_pkg::SID_W-1:0]    r_id,
    output axi_read_pkg::resp_t                    r_resp,
    output logic                                   r_last
);
    import axi_read_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    logic [SID_W-1:0]  id_q;
    logic [LEN_W-1:0]  len_q;
    logic              accepted;
    logic              taken;
    int                stall;

    // Handshakes sampled at the falling edge, outputs change 2 ns after the rising edge
    initial
    begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_id     = '0;
        r_resp   = RESP_OKAY;
        r_last   = 1'b0;
        @(negedge rst);
        @(posedge clk);
        #2;
        forever
        begin
            // Address phase with a randomly toggling ready
            accepted = 1'b0;
            ar_ready = ($urandom % 2) == 0;
            while (!accepted)
            begin
                @(negedge clk);
                if (ar_valid && ar_ready)
                begin
                    accepted = 1'b1;
                    addr_q   = ar_addr;
                    id_q     = ar_id;
                    len_q    = ar_len;
                end
                @(posedge clk);
                #2;
                ar_ready = !accepted && (($urandom % 2) == 0);
            end
            for (int beat = 0; beat <= int'(len_q); beat++)
            begin
                stall = int'($urandom % (MAX_STALL + 1));
                repeat (stall)
                begin
                    @(posedge clk);
                    #2;
                end
                r_valid = 1'b1;
                r_data  = DATA_W'(addr_q + ADDR_W'(4 * beat));
                r_id    = id_q;
                r_resp  = RESP_OKAY;
                r_last  = (beat == int'(len_q));
                // Beat held until the crossbar takes it
                taken = 1'b0;
                while (!taken)
                begin
                    @(negedge clk);
                    taken = r_ready;
                    @(posedge clk);
                    #2;
                end
                r_valid = 1'b0;
                r_last  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
